// ==== csr_unit.f ====
rtl/csr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_cmd_if.sv
rtl/csr_decode.sv
rtl/csr_counter_bank.sv
rtl/csr_machine_bank.sv
rtl/csr_access.sv
rtl/csr_unit.sv
tb/csr_checker.sv
tb/csr_unit_tb.sv

// ==== tb/csr_stimulus.txt ====
# op rd idx imm_sel imm reg_data ebreak issued pc exp_rdata kind exp_trap_pc exp_ret_addr
# op 0 none 1 write 2 set 3 clear; kind 0 none 1 exact 2 increasing; hex for idx imm data pc
0 0 000 0 00 00000000 0 0 00000000 00000000 0 00000100 00000000
0 1 305 0 00 00000000 0 0 00000000 00000100 1 00000100 00000000
0 1 301 0 00 00000000 0 0 00000000 40000104 1 00000100 00000000
0 1 f14 0 00 00000000 0 0 00000000 00000000 1 00000100 00000000
0 1 300 0 00 00000000 0 0 00000000 00000000 1 00000100 00000000
0 1 340 0 00 00000000 0 0 00000000 00000000 1 00000100 00000000
0 1 341 0 00 00000000 0 0 00000000 00000000 1 00000100 00000000
0 1 342 0 00 00000000 0 0 00000000 00000000 1 00000100 00000000
0 1 c02 0 00 00000000 0 0 00000000 00000000 1 00000100 00000000
0 1 c00 0 00 00000000 0 0 00000000 00000000 2 00000100 00000000
1 1 340 0 00 12345678 0 1 00000000 00000000 1 00000100 00000000
0 1 340 0 00 00000000 0 1 00000000 12345678 1 00000100 00000000
2 1 340 1 1f deadbeef 0 1 00000000 12345678 1 00000100 00000000
3 1 340 0 00 0000ff00 0 0 00000000 1234567f 1 00000100 00000000
3 1 340 1 0f 00000000 0 1 00000000 1234007f 1 00000100 00000000
1 1 340 1 15 00000000 0 0 00000000 12340070 1 00000100 00000000
2 1 340 0 00 80000000 0 0 00000000 00000015 1 00000100 00000000
0 1 340 0 00 00000000 0 1 00000000 80000015 1 00000100 00000000
1 1 300 0 00 ffffffff 0 0 00000000 00000000 1 00000100 00000000
0 1 300 0 00 00000000 0 0 00000000 00000088 1 00000100 00000000
3 1 300 1 08 00000000 0 0 00000000 00000088 1 00000100 00000000
0 1 300 0 00 00000000 0 0 00000000 00000080 1 00000100 00000000
1 1 305 0 00 00000203 0 0 00000000 00000100 1 00000100 00000000
0 1 305 0 00 00000000 0 0 00000000 00000200 1 00000200 00000000
1 1 341 0 00 00001235 0 0 00000000 00000000 1 00000200 00000000
0 1 341 0 00 00000000 0 0 00000000 00001234 1 00000200 00001234
1 1 301 0 00 ffffffff 0 0 00000000 40000104 1 00000200 00001234
0 1 301 0 00 00000000 0 0 00000000 40000104 1 00000200 00001234
1 1 f14 0 00 ffffffff 0 0 00000000 00000000 1 00000200 00001234
1 1 c80 0 00 ffffffff 0 0 00000000 00000000 1 00000200 00001234
1 0 c02 0 00 ffffffff 0 0 00000000 00000000 0 00000200 00001234
0 1 c02 0 00 00000000 0 0 00000000 00000005 1 00000200 00001234
1 1 140 0 00 ffffffff 0 0 00000000 00000000 1 00000200 00001234
2 1 240 1 1f 00000000 0 0 00000000 00000000 1 00000200 00001234
1 1 3ff 0 00 ffffffff 0 0 00000000 00000000 1 00000200 00001234
0 1 340 0 00 00000000 0 0 00000000 80000015 1 00000200 00001234
0 1 c00 0 00 00000000 0 0 00000000 00000000 2 00000200 00001234
0 0 000 0 00 00000000 1 1 00002468 00000000 0 00000200 00001234
0 1 341 0 00 00000000 0 0 00000000 00002468 1 00000200 00002468
0 1 342 0 00 00000000 0 0 00000000 00000003 1 00000200 00002468
1 1 341 0 00 0000aaaa 1 0 00003000 00002468 1 00000200 00002468
0 1 341 0 00 00000000 0 0 00000000 00003000 1 00000200 00003000
1 1 305 1 1e 00000000 0 0 00000000 00000200 1 00000200 00003000
0 0 000 0 00 00000000 1 0 00000010 00000000 0 0000001c 00003000
0 1 341 0 00 00000000 0 0 00000000 00000010 1 0000001c 00000010
0 1 c02 0 00 00000000 0 0 00000000 00000006 1 0000001c 00000010
0 1 c00 0 00 00000000 0 0 00000000 00000000 2 0000001c 00000010

// ==== tb/csr_unit_tb.sv ====
`timescale 1ns/1ns

module csr_unit_tb;

    localparam int    MAX_LINES    = 128;
    localparam int    RESET_CYCLES = 8;
    localparam string STIM_FILE    = "tb/csr_stimulus.txt";

    logic                           clk;
    logic                           rst_n;
    csr_pkg::csr_op_e               op;
    logic                           read;
    logic [11:0]                    idx;
    logic                           imm_sel;
    logic [4:0]                     imm;
    logic [csr_pkg::XLEN-1:0]       reg_data;
    logic                           ebreak;
    logic                           issued;
    logic [csr_pkg::PC_BITS-1:1]    pc;
    logic [csr_pkg::XLEN-1:0]       rdata;
    logic                           rd_valid;
    logic                           trap;
    logic [csr_pkg::PC_BITS-1:1]    trap_pc;
    logic [csr_pkg::PC_BITS-1:1]    ret_addr;

    // Expected response of the line driven one cycle earlier
    logic                           exp_valid;
    logic                           exp_rd;
    logic                           exp_trap;
    logic [1:0]                     exp_kind;
    logic [csr_pkg::XLEN-1:0]       exp_rdata;
    logic [csr_pkg::PC_BITS-1:1]    exp_trap_pc;
    logic [csr_pkg::PC_BITS-1:1]    exp_ret_addr;

    logic [31:0]    f_op      [MAX_LINES];
    logic [31:0]    f_rd      [MAX_LINES];
    logic [31:0]    f_idx     [MAX_LINES];
    logic [31:0]    f_imm_sel [MAX_LINES];
    logic [31:0]    f_imm     [MAX_LINES];
    logic [31:0]    f_reg     [MAX_LINES];
    logic [31:0]    f_ebreak  [MAX_LINES];
    logic [31:0]    f_issued  [MAX_LINES];
    logic [31:0]    f_pc      [MAX_LINES];
    logic [31:0]    f_rdata   [MAX_LINES];
    logic [31:0]    f_kind    [MAX_LINES];
    logic [31:0]    f_trap_pc [MAX_LINES];
    logic [31:0]    f_ret     [MAX_LINES];

    int     n_lines;
    bit     load_ok;
    logic   loaded;
    int     errors;
    int     checks;

    csr_unit csr_unit_inst
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_op           (op),
        .i_read         (read),
        .i_idx          (idx),
        .i_imm_sel      (imm_sel),
        .i_imm          (imm),
        .i_reg_data     (reg_data),
        .i_ebreak       (ebreak),
        .i_instr_issued (issued),
        .i_pc           (pc),
        .o_rdata        (rdata),
        .o_rd_valid     (rd_valid),
        .o_trap         (trap),
        .o_trap_pc      (trap_pc),
        .o_ret_addr     (ret_addr)
    );

    csr_checker csr_checker
    (
        .i_clk          (clk),
        .i_exp_valid    (exp_valid),
        .i_exp_rd       (exp_rd),
        .i_exp_trap     (exp_trap),
        .i_exp_kind     (exp_kind),
        .i_exp_rdata    (exp_rdata),
        .i_exp_trap_pc  (exp_trap_pc),
        .i_exp_ret_addr (exp_ret_addr),
        .i_rdata        (rdata),
        .i_rd_valid     (rd_valid),
        .i_trap         (trap),
        .i_trap_pc      (trap_pc),
        .i_ret_addr     (ret_addr),
        .o_errors       (errors),
        .o_checks       (checks)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_stimulus(output int count, output bit ok);
        int                 fd;
        int                 got;
        int                 fields;
        logic [8*256-1:0]   text;
        begin
            count = 0;
            ok    = 1'b1;
            fd    = $fopen(STIM_FILE, "r");
            if (fd == 0)
            begin
                $display("Could not open the stimulus file %s", STIM_FILE);
                ok = 1'b0;
            end
            else
            begin
                while (!$feof(fd) && ok)
                begin
                    text = '0;
                    got  = $fgets(text, fd);
                    if (got > 0 && count < MAX_LINES)
                    begin
                        // Comment and blank lines scan zero fields
                        fields = $sscanf(text, "%d %d %h %d %h %h %d %d %h %h %d %h %h",
                                         f_op[count], f_rd[count], f_idx[count],
                                         f_imm_sel[count], f_imm[count], f_reg[count],
                                         f_ebreak[count], f_issued[count], f_pc[count],
                                         f_rdata[count], f_kind[count], f_trap_pc[count],
                                         f_ret[count]);
                        if (fields == 13)
                        begin
                            count = count + 1;
                        end
                        else if (fields > 0)
                        begin
                            $display("Stimulus line after entry %0d is malformed", count);
                            ok = 1'b0;
                        end
                    end
                    else if (got > 0)
                    begin
                        $display("Stimulus file holds more than %0d commands", MAX_LINES);
                        ok = 1'b0;
                    end
                end
                $fclose(fd);
            end
            if (ok && count == 0)
            begin
                $display("Stimulus file holds no commands");
                ok = 1'b0;
            end
        end
    endtask

    task automatic drive_line(input int k);
        begin
            op       = csr_pkg::csr_op_e'(f_op[k][1:0]);
            read     = f_rd[k][0];
            idx      = f_idx[k][11:0];
            imm_sel  = f_imm_sel[k][0];
            imm      = f_imm[k][4:0];
            reg_data = f_reg[k];
            ebreak   = f_ebreak[k][0];
            issued   = f_issued[k][0];
            pc       = f_pc[k][csr_pkg::PC_BITS-1:1];
        end
    endtask

    task automatic drive_idle;
        begin
            op       = csr_pkg::CSR_NONE;
            read     = 1'b0;
            idx      = '0;
            imm_sel  = 1'b0;
            imm      = '0;
            reg_data = '0;
            ebreak   = 1'b0;
            issued   = 1'b0;
            pc       = '0;
        end
    endtask

    task automatic set_expected(input int k);
        begin
            exp_valid    = 1'b1;
            exp_rd       = f_rd[k][0];
            exp_trap     = f_ebreak[k][0];
            exp_kind     = f_kind[k][1:0];
            exp_rdata    = f_rdata[k];
            exp_trap_pc  = f_trap_pc[k][csr_pkg::PC_BITS-1:1];
            exp_ret_addr = f_ret[k][csr_pkg::PC_BITS-1:1];
        end
    endtask

    initial
    begin : main
        int k;
        rst_n        = 1'b0;
        drive_idle();
        exp_valid    = 1'b0;
        exp_rd       = 1'b0;
        exp_trap     = 1'b0;
        exp_kind     = '0;
        exp_rdata    = '0;
        exp_trap_pc  = '0;
        exp_ret_addr = '0;
        load_stimulus(n_lines, load_ok);
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        if (load_ok)
        begin
            for (k = 0; k < n_lines; k++)
            begin
                @(negedge clk);
                drive_line(k);
                if (k > 0)
                begin
                    set_expected(k - 1);
                end
            end
            @(negedge clk);
            drive_idle();
            set_expected(n_lines - 1);
            @(negedge clk);
        end
        exp_valid = 1'b0;
        $display("Commands: %0d, checks: %0d, errors: %0d", n_lines, checks, errors);
        if (load_ok && errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Reset, one cycle per command and some slack
    initial
    begin : watchdog
        int cycles;
        int limit;
        cycles = 0;
        wait (loaded === 1'b1);
        limit = RESET_CYCLES + n_lines + 20;
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Run timed out after %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== tb/csr_checker.sv ====
`timescale 1ns/1ns

module csr_checker
(
    input  logic                            i_clk,
    input  logic                            i_exp_valid,
    input  logic                            i_exp_rd,
    input  logic                            i_exp_trap,
    input  logic [1:0]                      i_exp_kind,
    input  logic [csr_pkg::XLEN-1:0]        i_exp_rdata,
    input  logic [csr_pkg::PC_BITS-1:1]     i_exp_trap_pc,
    input  logic [csr_pkg::PC_BITS-1:1]     i_exp_ret_addr,
    input  logic [csr_pkg::XLEN-1:0]        i_rdata,
    input  logic                            i_rd_valid,
    input  logic                            i_trap,
    input  logic [csr_pkg::PC_BITS-1:1]     i_trap_pc,
    input  logic [csr_pkg::PC_BITS-1:1]     i_ret_addr,
    output int                              o_errors,
    output int                              o_checks
);

    localparam logic [1:0] KIND_EXACT      = 2'd1;
    localparam logic [1:0] KIND_INCREASING = 2'd2;

    logic [csr_pkg::XLEN-1:0]   last_cycle;
    logic                       have_cycle;

    initial
    begin
        o_errors   = 0;
        o_checks   = 0;
        last_cycle = '0;
        have_cycle = 1'b0;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        begin
            o_checks = o_checks + 1;
            if (actual !== expected)
            begin
                o_errors = o_errors + 1;
                $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            end
        end
    endtask

    // Cycle counter low half must move up between reads
    task automatic check_increasing(input logic [31:0] actual);
        begin
            o_checks = o_checks + 1;
            if ($isunknown(actual) || (have_cycle && actual <= last_cycle))
            begin
                o_errors = o_errors + 1;
                $display("[ERROR] %0t ns: o_rdata expected above %h, got %h",
                         $time, last_cycle, actual);
            end
            last_cycle = actual;
            have_cycle = 1'b1;
        end
    endtask

    always @(posedge i_clk)
    begin
        if (i_exp_valid)
        begin
            compare_value("o_rd_valid", i_exp_rd, i_rd_valid);
            compare_value("o_trap", i_exp_trap, i_trap);
            if (i_rd_valid && i_exp_kind == KIND_EXACT)
            begin
                compare_value("o_rdata", i_exp_rdata, i_rdata);
            end
            else if (i_rd_valid && i_exp_kind == KIND_INCREASING)
            begin
                check_increasing(i_rdata);
            end
            if (i_trap)
            begin
                compare_value("o_trap_pc", i_exp_trap_pc, i_trap_pc);
            end
            compare_value("o_ret_addr", i_exp_ret_addr, i_ret_addr);   // Current mepc
        end
    end

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ns

module csr_unit
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  csr_pkg::csr_op_e                i_op,
    input  logic                            i_read,
    input  logic [11:0]                     i_idx,
    input  logic                            i_imm_sel,
    input  logic [4:0]                      i_imm,
    input  logic [csr_pkg::XLEN-1:0]        i_reg_data,
    input  logic                            i_ebreak,
    input  logic                            i_instr_issued,
    input  logic [csr_pkg::PC_BITS-1:1]     i_pc,
    output logic [csr_pkg::XLEN-1:0]        o_rdata,
    output logic                            o_rd_valid,
    output logic                            o_trap,
    output logic [csr_pkg::PC_BITS-1:1]     o_trap_pc,
    output logic [csr_pkg::PC_BITS-1:1]     o_ret_addr
);

    csr_cmd_if cmd_if ();

    csr_decode u_decode
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op       (i_op),
        .i_read     (i_read),
        .i_idx      (i_idx),
        .i_imm_sel  (i_imm_sel),
        .i_imm      (i_imm),
        .i_reg_data (i_reg_data),
        .i_ebreak   (i_ebreak),
        .i_pc       (i_pc),
        .o_cmd      (cmd_if.stage)
    );

    csr_access u_access
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_issued (i_instr_issued),
        .i_cmd          (cmd_if.bank),
        .o_rdata        (o_rdata),
        .o_rd_valid     (o_rd_valid),
        .o_trap         (o_trap),
        .o_trap_pc      (o_trap_pc),
        .o_ret_addr     (o_ret_addr)
    );

endmodule

// ==== rtl/csr_access.sv ====
`timescale 1ns/1ns

module csr_access
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_instr_issued,
    csr_cmd_if.bank                         i_cmd,
    output logic [csr_pkg::XLEN-1:0]        o_rdata,
    output logic                            o_rd_valid,
    output logic                            o_trap,
    output logic [csr_pkg::PC_BITS-1:1]     o_trap_pc,
    output logic [csr_pkg::PC_BITS-1:1]     o_ret_addr
);

    logic [csr_pkg::XLEN-1:0]   rdata_user;
    logic [csr_pkg::XLEN-1:0]   rdata_machine;
    logic                       sel_user;
    logic                       sel_machine;

    // Counters sit in the Cxx block, other user addresses read zero
    assign sel_user    = (i_cmd.cat == csr_pkg::CAT_USER)
                         && (i_cmd.idx[11:10] == csr_pkg::ADDR_CYCLE[11:10]);
    assign sel_machine = (i_cmd.cat == csr_pkg::CAT_MACHINE);

    csr_counter_bank u_counter
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_sel          (sel_user),
        .i_idx          (i_cmd.idx[7:0]),
        .i_instr_issued (i_instr_issued),
        .o_data         (rdata_user)
    );

    csr_machine_bank u_machine
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_sel      (sel_machine),
        .i_idx      (i_cmd.idx),
        .i_op       (i_cmd.op),
        .i_wdata    (i_cmd.wdata),
        .i_ebreak   (i_cmd.ebreak),
        .i_pc       (i_cmd.pc),
        .o_data     (rdata_machine),
        .o_trap_pc  (o_trap_pc),
        .o_ret_addr (o_ret_addr)
    );

    always_comb
    begin
        case (i_cmd.cat)
            csr_pkg::CAT_USER:    o_rdata = rdata_user;
            csr_pkg::CAT_MACHINE: o_rdata = rdata_machine;
            default:              o_rdata = '0;   // S and H levels not implemented
        endcase
    end

    assign o_rd_valid = i_cmd.rd;
    assign o_trap     = i_cmd.ebreak;

endmodule

// ==== rtl/csr_machine_bank.sv ====
`timescale 1ns/1ns

module csr_machine_bank
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_sel,
    input  logic [11:0]                     i_idx,
    input  csr_pkg::csr_op_e                i_op,
    input  logic [csr_pkg::XLEN-1:0]        i_wdata,
    input  logic                            i_ebreak,
    input  logic [csr_pkg::PC_BITS-1:1]     i_pc,
    output logic [csr_pkg::XLEN-1:0]        o_data,
    output logic [csr_pkg::PC_BITS-1:1]     o_trap_pc,
    output logic [csr_pkg::PC_BITS-1:1]     o_ret_addr
);

    logic [csr_pkg::XLEN-1:0]   mstatus;
    logic [csr_pkg::XLEN-1:0]   mtvec;
    logic [csr_pkg::XLEN-1:0]   mscratch;
    logic [csr_pkg::XLEN-1:0]   mepc;
    logic [csr_pkg::XLEN-1:0]   mcause;

    logic [csr_pkg::XLEN-1:0]   rdata;
    logic [csr_pkg::XLEN-1:0]   new_val;
    logic                       wr_en;

    always_comb
    begin
        case (i_idx)
            csr_pkg::ADDR_MSTATUS:  rdata = mstatus;
            csr_pkg::ADDR_MISA:     rdata = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MTVEC:    rdata = mtvec;
            csr_pkg::ADDR_MSCRATCH: rdata = mscratch;
            csr_pkg::ADDR_MEPC:     rdata = mepc;
            csr_pkg::ADDR_MCAUSE:   rdata = mcause;
            csr_pkg::ADDR_MHARTID:  rdata = '0;   // Single hart
            default:                rdata = '0;
        endcase
    end

    // Read-modify-write on the old value
    always_comb
    begin
        case (i_op)
            csr_pkg::CSR_WRITE: new_val = i_wdata;
            csr_pkg::CSR_SET:   new_val = rdata | i_wdata;
            csr_pkg::CSR_CLEAR: new_val = rdata & ~i_wdata;
            default:            new_val = rdata;
        endcase
    end

    assign wr_en = i_sel && (i_op != csr_pkg::CSR_NONE);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            mstatus  <= '0;
            mtvec    <= trap_pkg::MTVEC_RESET;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end
        else if (i_ebreak)
        begin
            // Trap capture wins over any write in the same command
            mepc   <= {i_pc, 1'b0};
            mcause <= trap_pkg::CAUSE_BREAKPOINT;
        end
        else if (wr_en)
        begin
            case (i_idx)
                csr_pkg::ADDR_MSTATUS:  mstatus  <= new_val & csr_pkg::MSTATUS_MASK;
                csr_pkg::ADDR_MTVEC:    mtvec    <= new_val & trap_pkg::MTVEC_ALIGN_MASK;
                csr_pkg::ADDR_MSCRATCH: mscratch <= new_val;
                csr_pkg::ADDR_MEPC:     mepc     <= {new_val[csr_pkg::XLEN-1:1], 1'b0};
                csr_pkg::ADDR_MCAUSE:   mcause   <= new_val;
                default:
                begin
                    // misa, mhartid and unmapped addresses ignore writes
                end
            endcase
        end
    end

    assign o_data     = rdata;
    assign o_trap_pc  = mtvec[csr_pkg::PC_BITS-1:1];
    assign o_ret_addr = mepc[csr_pkg::PC_BITS-1:1];

endmodule

// ==== rtl/csr_counter_bank.sv ====
`timescale 1ns/1ns

module csr_counter_bank
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_sel,
    input  logic [7:0]                  i_idx,
    input  logic                        i_instr_issued,
    output logic [csr_pkg::XLEN-1:0]    o_data
);

    logic [63:0]                cycle;
    logic [63:0]                instret;
    logic [csr_pkg::XLEN-1:0]   rdata;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cycle <= '0;
        end
        else
        begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            instret <= '0;
        end
        else if (i_instr_issued)
        begin
            instret <= instret + 64'd1;
        end
    end

    // Only the low address byte is decoded here
    always_comb
    begin
        case (i_idx)
            csr_pkg::ADDR_CYCLE[7:0]:    rdata = cycle[31:0];
            csr_pkg::ADDR_CYCLEH[7:0]:   rdata = cycle[63:32];
            csr_pkg::ADDR_INSTRET[7:0]:  rdata = instret[31:0];
            csr_pkg::ADDR_INSTRETH[7:0]: rdata = instret[63:32];
            default:                     rdata = '0;
        endcase
    end

    assign o_data = i_sel ? rdata : '0;

endmodule

// ==== rtl/csr_decode.sv ====
`timescale 1ns/1ns

module csr_decode
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  csr_pkg::csr_op_e                i_op,
    input  logic                            i_read,
    input  logic [11:0]                     i_idx,
    input  logic                            i_imm_sel,
    input  logic [4:0]                      i_imm,
    input  logic [csr_pkg::XLEN-1:0]        i_reg_data,
    input  logic                            i_ebreak,
    input  logic [csr_pkg::PC_BITS-1:1]     i_pc,
    csr_cmd_if.stage                        o_cmd
);

    logic [csr_pkg::XLEN-1:0]   operand;
    csr_pkg::csr_cat_e          category;

    // Immediate form zero-extends the 5-bit field
    assign operand = i_imm_sel ? {{(csr_pkg::XLEN-5){1'b0}}, i_imm} : i_reg_data;

    assign category = csr_pkg::csr_cat_e'(i_idx[9:8]);

    // Control flags
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_cmd.op     <= csr_pkg::CSR_NONE;
            o_cmd.rd     <= 1'b0;
            o_cmd.ebreak <= 1'b0;
        end
        else
        begin
            o_cmd.op     <= i_op;
            o_cmd.rd     <= i_read;
            o_cmd.ebreak <= i_ebreak;
        end
    end

    // Payload, only meaningful alongside the flags above
    always_ff @(posedge i_clk)
    begin
        o_cmd.cat   <= category;
        o_cmd.idx   <= i_idx;
        o_cmd.wdata <= operand;
        o_cmd.pc    <= i_pc;
    end

endmodule

// ==== rtl/csr_cmd_if.sv ====
`timescale 1ns/1ns

interface csr_cmd_if;

    csr_pkg::csr_op_e               op;
    logic                           rd;
    csr_pkg::csr_cat_e              cat;
    logic [11:0]                    idx;     // full address, sub-category included
    logic [csr_pkg::XLEN-1:0]       wdata;
    logic                           ebreak;
    logic [csr_pkg::PC_BITS-1:1]    pc;

    modport stage
    (
        output op,
        output rd,
        output cat,
        output idx,
        output wdata,
        output ebreak,
        output pc
    );

    modport bank
    (
        input  op,
        input  rd,
        input  cat,
        input  idx,
        input  wdata,
        input  ebreak,
        input  pc
    );

endinterface

// ==== rtl/trap_pkg.sv ====
package trap_pkg;

    // Exception code for ebreak
    localparam logic [csr_pkg::XLEN-1:0] CAUSE_BREAKPOINT = 32'd3;

    // Direct mode vector base after reset
    localparam logic [csr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100;

    // Mode bits are not kept
    localparam logic [csr_pkg::XLEN-1:0] MTVEC_ALIGN_MASK = 32'hFFFF_FFFC;

endpackage

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    localparam int XLEN    = 32;
    localparam int PC_BITS = 32;   // PC carried as [PC_BITS-1:1]

    typedef enum logic [1:0]
    {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // Privilege level from address bits 9:8
    typedef enum logic [1:0]
    {
        CAT_USER       = 2'd0,
        CAT_SUPERVISOR = 2'd1,
        CAT_HYPERVISOR = 2'd2,
        CAT_MACHINE    = 2'd3
    } csr_cat_e;

    // User counters, read-only
    localparam logic [11:0] ADDR_CYCLE    = 12'hC00;
    localparam logic [11:0] ADDR_INSTRET  = 12'hC02;
    localparam logic [11:0] ADDR_CYCLEH   = 12'hC80;
    localparam logic [11:0] ADDR_INSTRETH = 12'hC82;

    localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] ADDR_MISA     = 12'h301;
    localparam logic [11:0] ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] ADDR_MEPC     = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] ADDR_MHARTID  = 12'hF14;

    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4000_0104;  // MXL=1, C and I
    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_0088;  // MPIE, MIE

endpackage
